// File: all.f
hw/hist_geom_pkg.sv
hw/hist_ctrl_pkg.sv
hw/acq_sequencer.sv
hw/event_router.sv
hw/hist_bank.sv
hw/hist_readout_axil.sv
hw/hist_top.sv
dv/hist_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the histogram testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module hist_tb -f all.f -o hist_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/hist_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "NO ERRORS"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

// File: dv/hist_tb.sv
`timescale 1ns/1ps

module hist_tb;

    localparam int TIMEOUT = 100; // cycles or polls per wait
    localparam int SAT_MAX = (1 << hist_geom_pkg::COUNT_BITS) - 1;

    logic                                clk;
    logic                                res;
    logic                                ev_valid;
    logic [hist_geom_pkg::PIX_BITS-1:0]  ev_pixel;
    logic [hist_geom_pkg::BIN_BITS-1:0]  ev_bin;
    logic                                acq_end;
    logic                                acq_active;
    logic                                awvalid;
    logic                                awready;
    logic [hist_ctrl_pkg::ADDR_BITS-1:0] awaddr;
    logic                                wvalid;
    logic                                wready;
    logic [hist_ctrl_pkg::DATA_BITS-1:0] wdata;
    logic [3:0]                          wstrb;
    logic                                bvalid;
    logic                                bready;
    logic [1:0]                          bresp;
    logic                                arvalid;
    logic                                arready;
    logic [hist_ctrl_pkg::ADDR_BITS-1:0] araddr;
    logic                                rvalid;
    logic                                rready;
    logic [hist_ctrl_pkg::DATA_BITS-1:0] rdata;
    logic [1:0]                          rresp;

    // event counts of the frame being acquired and of the last finished one
    int          cur_model  [hist_geom_pkg::NUM_BANKS][hist_geom_pkg::NUM_BINS];
    int          done_model [hist_geom_pkg::NUM_BANKS][hist_geom_pkg::NUM_BINS];
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    hist_top u_hist_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] expected_count(input int b, input int k);
        return (done_model[b][k] > SAT_MAX) ? 32'(SAT_MAX) : 32'(done_model[b][k]);
    endfunction

    function automatic logic [11:0] bin_addr(input int b, input int k);
        return hist_ctrl_pkg::ADDR_BIN_BASE + 12'(4 * (b * hist_geom_pkg::NUM_BINS + k));
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s never came", $time, what);
        $display("ERRORS FOUND");
        $fatal(1, "wait ran past its limit");
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!awready && n < TIMEOUT);
        if (!awready) report_timeout("awready");
        check_value("wready", 32'(wready), 32'd1);
        @(negedge clk); // accepted on the edge before
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_value("awready after accept", 32'(awready), 32'd0);
        check_value("wready after accept", 32'(wready), 32'd0);
        n = 0;
        while (!bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) report_timeout("bvalid");
        resp = bresp;
        @(negedge clk);
    endtask

    // hold > 0 keeps rready low that many cycles after rvalid
    task automatic axi_read(input logic [11:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!arready && n < TIMEOUT);
        if (!arready) report_timeout("arready");
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid) report_timeout("rvalid");
        data = rdata;
        resp = rresp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("rvalid held", 32'(rvalid), 32'd1);
            check_value("rdata held", rdata, data);
        end
        rready = 1'b1;
        @(negedge clk);
    endtask

    task automatic read_expect(input string name, input logic [11:0] addr,
                               input logic [31:0] exp);
        axi_read(addr, 0, rd_data, rd_resp);
        check_value({name, " rresp"}, 32'(rd_resp), 32'(hist_ctrl_pkg::OKAY));
        check_value(name, rd_data, exp);
    endtask

    task automatic compare_bins();
        for (int b = 0; b < hist_geom_pkg::NUM_BANKS; b++) begin
            for (int k = 0; k < hist_geom_pkg::NUM_BINS; k++) begin
                read_expect($sformatf("bank%0d bin%0d", b, k), bin_addr(b, k),
                            expected_count(b, k));
            end
        end
    endtask

    task automatic drive_cycle(input logic valid, input int pix, input int bin,
                               input logic end_pulse);
        ev_valid = valid;
        ev_pixel = hist_geom_pkg::PIX_BITS'(pix);
        ev_bin   = hist_geom_pkg::BIN_BITS'(bin);
        acq_end  = end_pulse;
        if (valid && acq_active) cur_model[pix][bin]++; // router takes it on the next edge
        @(negedge clk);
        ev_valid = 1'b0;
        acq_end  = 1'b0;
    endtask

    task automatic random_events(input int count, input logic end_pulse);
        for (int i = 0; i < count; i++) begin
            drive_cycle(1'($urandom_range(1, 0)),
                        int'($urandom_range(hist_geom_pkg::NUM_BANKS - 1, 0)),
                        int'($urandom_range(hist_geom_pkg::NUM_BINS - 1, 0)),
                        end_pulse && (i == count - 1));
        end
    endtask

    // always valid, so a leak past the gate shows up
    task automatic stray_event();
        drive_cycle(1'b1, int'($urandom_range(hist_geom_pkg::NUM_BANKS - 1, 0)),
                    int'($urandom_range(hist_geom_pkg::NUM_BINS - 1, 0)), 1'b0);
    endtask

    task automatic finish_frame();
        for (int w = 0; w < hist_geom_pkg::ACQ_NUM; w++) begin
            random_events(5, 1'b1);
        end
        // swap and clear cycles, these must be dropped
        for (int i = 0; i < 2; i++) begin
            check_value("acq_active after last window", 32'(acq_active), 32'd0);
            stray_event();
        end
    endtask

    task automatic wait_active();
        int n;
        n = 0;
        while (!acq_active && n < TIMEOUT) begin
            stray_event(); // dropped until acquisition starts
            n++;
        end
        if (!acq_active) report_timeout("acq_active");
    endtask

    task automatic wait_frame(input int f);
        int n;
        n = 0;
        do begin
            axi_read(hist_ctrl_pkg::ADDR_STATUS, 0, rd_data, rd_resp);
            n++;
        end while (rd_data[15:8] != 8'(f) && n < TIMEOUT);
        if (rd_data[15:8] != 8'(f)) report_timeout("frame_count step");
    endtask

    task automatic close_frame();
        for (int b = 0; b < hist_geom_pkg::NUM_BANKS; b++) begin
            for (int k = 0; k < hist_geom_pkg::NUM_BINS; k++) begin
                done_model[b][k] = cur_model[b][k];
                cur_model[b][k]  = 0;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h9001511d));
        res      = 1'b0;
        ev_valid = 1'b0;
        ev_pixel = '0;
        ev_bin   = '0;
        acq_end  = 1'b0;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        bready   = 1'b1;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b1;
        close_frame();
        close_frame();
        repeat (5) @(negedge clk);
        res = 1'b1;
        @(negedge clk);

        check_value("acq_active", 32'(acq_active), 32'd0);
        read_expect("status after reset", hist_ctrl_pkg::ADDR_STATUS, 32'h0);
        repeat (8) stray_event(); // idle, dropped
        axi_write(hist_ctrl_pkg::ADDR_CTRL, 32'h1, rd_resp);
        check_value("bresp ctrl", 32'(rd_resp), 32'(hist_ctrl_pkg::OKAY));
        wait_active();
        read_expect("status running", hist_ctrl_pkg::ADDR_STATUS, 32'h1);

        for (int f = 1; f <= 3; f++) begin
            wait_active();
            if (f == 3) begin
                axi_write(hist_ctrl_pkg::ADDR_CTRL, 32'h0, rd_resp); // stop after this one
                check_value("bresp ctrl stop", 32'(rd_resp), 32'(hist_ctrl_pkg::OKAY));
            end
            random_events(40, 1'b0);
            if (f == 1) begin
                for (int i = 0; i < 300; i++) drive_cycle(1'b1, 2, 5, 1'b0);
            end
            if (f > 1) compare_bins(); // previous frame still on the read page
            finish_frame();
            wait_frame(f);
            close_frame();
            compare_bins();
            if (f == 1) read_expect("saturated bin", bin_addr(2, 5), 32'(SAT_MAX));
        end
        read_expect("status stopped", hist_ctrl_pkg::ADDR_STATUS, 32'h0000_0300);

        axi_read(12'h008, 0, rd_data, rd_resp);
        check_value("rresp 0x008", 32'(rd_resp), 32'(hist_ctrl_pkg::SLVERR));
        axi_read(12'h200, 0, rd_data, rd_resp);
        check_value("rresp 0x200", 32'(rd_resp), 32'(hist_ctrl_pkg::SLVERR));
        axi_write(hist_ctrl_pkg::ADDR_STATUS, 32'h1, rd_resp);
        check_value("bresp status", 32'(rd_resp), 32'(hist_ctrl_pkg::SLVERR));
        axi_read(bin_addr(2, 5), 3, rd_data, rd_resp);
        check_value("stalled bin read", rd_data, expected_count(2, 5));

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: hw/hist_top.sv
`timescale 1ns/1ps

module hist_top (
    input  logic                                clk,
    input  logic                                res,
    input  logic                                ev_valid,
    input  logic [hist_geom_pkg::PIX_BITS-1:0]  ev_pixel,
    input  logic [hist_geom_pkg::BIN_BITS-1:0]  ev_bin,
    input  logic                                acq_end,
    output logic                                acq_active,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [hist_ctrl_pkg::ADDR_BITS-1:0] awaddr,
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [hist_ctrl_pkg::DATA_BITS-1:0] wdata,
    input  logic [3:0]                          wstrb,
    output logic                                bvalid,
    input  logic                                bready,
    output logic [1:0]                          bresp,
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [hist_ctrl_pkg::ADDR_BITS-1:0] araddr,
    output logic                                rvalid,
    input  logic                                rready,
    output logic [hist_ctrl_pkg::DATA_BITS-1:0] rdata,
    output logic [1:0]                          rresp
);

    hist_ctrl_pkg::seq_state_e            state;
    hist_ctrl_pkg::axi_resp_e             bresp_e;
    hist_ctrl_pkg::axi_resp_e             rresp_e;
    logic                                 run;
    logic                                 clr_page;
    logic                                 wr_page;
    logic [hist_ctrl_pkg::FRAME_BITS-1:0] frame_count;
    logic [hist_geom_pkg::NUM_BANKS-1:0]  inc_valid;
    logic [hist_geom_pkg::BIN_BITS-1:0]   inc_bin;
    logic [hist_geom_pkg::BIN_BITS-1:0]   rd_bin;
    logic [hist_geom_pkg::COUNT_BITS-1:0] rd_count [hist_geom_pkg::NUM_BANKS];

    assign bresp = bresp_e;
    assign rresp = rresp_e;

    acq_sequencer u_seq (
        .clk, .res, .run, .acq_end, .state, .acq_active, .clr_page, .wr_page, .frame_count
    );

    event_router u_router (
        .clk, .res, .acq_active, .ev_valid, .ev_pixel, .ev_bin, .inc_valid, .inc_bin
    );

    for (genvar b = 0; b < hist_geom_pkg::NUM_BANKS; b++) begin : g_bank
        hist_bank u_bank (
            .clk, .res, .inc_valid(inc_valid[b]), .inc_bin, .clr_page, .wr_page,
            .rd_bin, .rd_count(rd_count[b])
        );
    end

    hist_readout_axil u_axil (
        .clk, .res, .awvalid, .awaddr, .wvalid, .wdata, .wstrb, .bready,
        .arvalid, .araddr, .rready, .state, .frame_count, .rd_count,
        .awready, .wready, .bvalid, .bresp(bresp_e), .arready, .rvalid, .rdata,
        .rresp(rresp_e), .run, .rd_bin
    );

endmodule

// File: hw/hist_readout_axil.sv
`timescale 1ns/1ps

module hist_readout_axil (
    input  logic                                 clk,
    input  logic                                 res,
    input  logic                                 awvalid,
    input  logic [hist_ctrl_pkg::ADDR_BITS-1:0]  awaddr,
    input  logic                                 wvalid,
    input  logic [hist_ctrl_pkg::DATA_BITS-1:0]  wdata,
    input  logic [3:0]                           wstrb,
    input  logic                                 bready,
    input  logic                                 arvalid,
    input  logic [hist_ctrl_pkg::ADDR_BITS-1:0]  araddr,
    input  logic                                 rready,
    input  hist_ctrl_pkg::seq_state_e            state,
    input  logic [hist_ctrl_pkg::FRAME_BITS-1:0] frame_count,
    input  logic [hist_geom_pkg::COUNT_BITS-1:0] rd_count [hist_geom_pkg::NUM_BANKS],
    output logic                                 awready,
    output logic                                 wready,
    output logic                                 bvalid,
    output hist_ctrl_pkg::axi_resp_e             bresp,
    output logic                                 arready,
    output logic                                 rvalid,
    output logic [hist_ctrl_pkg::DATA_BITS-1:0]  rdata,
    output hist_ctrl_pkg::axi_resp_e             rresp,
    output logic                                 run,
    output logic [hist_geom_pkg::BIN_BITS-1:0]   rd_bin
);

    logic                                 wr_hs;
    logic                                 rd_hs;
    logic [hist_ctrl_pkg::ADDR_BITS-1:0]  bin_off;
    logic [hist_geom_pkg::PIX_BITS-1:0]   bank_sel;
    logic                                 in_bins;
    logic [hist_ctrl_pkg::DATA_BITS-1:0]  rd_word;
    hist_ctrl_pkg::axi_resp_e             rd_resp;

    assign wr_hs = awready && awvalid && wvalid;
    assign rd_hs = arready && arvalid;

    // word index inside the bin area is bank * NUM_BINS + bin
    assign bin_off  = araddr - hist_ctrl_pkg::ADDR_BIN_BASE;
    assign rd_bin   = bin_off[2 +: hist_geom_pkg::BIN_BITS];
    assign bank_sel = bin_off[2 + hist_geom_pkg::BIN_BITS +: hist_geom_pkg::PIX_BITS];
    assign in_bins  = (araddr >= hist_ctrl_pkg::ADDR_BIN_BASE) && (bin_off[1:0] == 2'b00) &&
        (bin_off >> (2 + hist_geom_pkg::BIN_BITS + hist_geom_pkg::PIX_BITS)) == '0;

    always_comb begin
        rd_word = '0;
        rd_resp = hist_ctrl_pkg::OKAY;
        if (araddr == hist_ctrl_pkg::ADDR_CTRL) begin
            rd_word[0] = run;
        end else if (araddr == hist_ctrl_pkg::ADDR_STATUS) begin
            rd_word[0]    = (state != hist_ctrl_pkg::IDLE);
            rd_word[15:8] = frame_count;
        end else if (in_bins) begin
            rd_word[hist_geom_pkg::COUNT_BITS-1:0] = rd_count[bank_sel];
        end else begin
            rd_resp = hist_ctrl_pkg::SLVERR;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            run     <= 1'b0;
        end else begin
            // one-cycle ready pulses, one transaction in flight per channel
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            arready <= arvalid && !arready && !rvalid;
            if (bvalid && bready) bvalid <= 1'b0;
            if (wr_hs) bvalid <= 1'b1;
            if (rvalid && rready) rvalid <= 1'b0;
            if (rd_hs) rvalid <= 1'b1;
            if (wr_hs && awaddr == hist_ctrl_pkg::ADDR_CTRL && wstrb[0]) run <= wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= (awaddr == hist_ctrl_pkg::ADDR_CTRL) ? hist_ctrl_pkg::OKAY
                                                          : hist_ctrl_pkg::SLVERR;
        end
        if (rd_hs) begin
            rdata <= rd_word; // bins sampled at acceptance
            rresp <= rd_resp;
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!res)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// File: hw/hist_bank.sv
`timescale 1ns/1ps

module hist_bank (
    input  logic                                 clk,
    input  logic                                 res,
    input  logic                                 inc_valid,
    input  logic [hist_geom_pkg::BIN_BITS-1:0]   inc_bin,
    input  logic                                 clr_page,
    input  logic                                 wr_page,
    input  logic [hist_geom_pkg::BIN_BITS-1:0]   rd_bin,
    output logic [hist_geom_pkg::COUNT_BITS-1:0] rd_count
);

    // two pages of bin counters
    logic [hist_geom_pkg::COUNT_BITS-1:0] cnt [2][hist_geom_pkg::NUM_BINS];
    logic                                 rd_page;
    logic [hist_geom_pkg::COUNT_BITS-1:0] cur;

    assign rd_page = ~wr_page; // last finished frame
    assign cur     = cnt[wr_page][inc_bin];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cnt <= '{default: '{default: '0}};
        end else if (clr_page) begin
            for (int k = 0; k < hist_geom_pkg::NUM_BINS; k++) begin
                cnt[wr_page][k] <= '0;
            end
        end else if (inc_valid && cur != '1) begin
            cnt[wr_page][inc_bin] <= cur + 1'b1; // holds at top value
        end
    end

    assign rd_count = cnt[rd_page][rd_bin];

    // router never delivers into a page being cleared
    a_no_clr_inc: assert property (@(posedge clk) disable iff (!res)
        !(clr_page && inc_valid));

endmodule

// File: hw/event_router.sv
`timescale 1ns/1ps

module event_router (
    input  logic                                clk,
    input  logic                                res,
    input  logic                                acq_active,
    input  logic                                ev_valid,
    input  logic [hist_geom_pkg::PIX_BITS-1:0]  ev_pixel,
    input  logic [hist_geom_pkg::BIN_BITS-1:0]  ev_bin,
    output logic [hist_geom_pkg::NUM_BANKS-1:0] inc_valid,
    output logic [hist_geom_pkg::BIN_BITS-1:0]  inc_bin
);

    logic [hist_geom_pkg::NUM_BANKS-1:0] bank_sel;

    // pixel index to one-hot bank, events outside acquisition dropped
    always_comb begin
        bank_sel = '0;
        for (int b = 0; b < hist_geom_pkg::NUM_BANKS; b++) begin
            bank_sel[b] = ev_valid && acq_active &&
                          (ev_pixel == hist_geom_pkg::PIX_BITS'(b));
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            inc_valid <= '0;
        end else begin
            inc_valid <= bank_sel;
        end
    end

    always_ff @(posedge clk) begin
        inc_bin <= ev_bin; // shared by all banks
    end

    a_onehot: assert property (@(posedge clk) disable iff (!res)
        $onehot0(inc_valid));

endmodule

// File: hw/acq_sequencer.sv
`timescale 1ns/1ps

module acq_sequencer (
    input  logic                                 clk,
    input  logic                                 res,
    input  logic                                 run,
    input  logic                                 acq_end,
    output hist_ctrl_pkg::seq_state_e            state,
    output logic                                 acq_active,
    output logic                                 clr_page,
    output logic                                 wr_page,
    output logic [hist_ctrl_pkg::FRAME_BITS-1:0] frame_count
);

    logic [hist_geom_pkg::ACQ_CNT_BITS-1:0] acq_cnt; // windows seen this frame

    assign acq_active = (state == hist_ctrl_pkg::ACQUIRE);
    assign clr_page   = (state == hist_ctrl_pkg::CLEAR);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= hist_ctrl_pkg::IDLE;
            acq_cnt     <= '0;
            wr_page     <= 1'b0;
            frame_count <= '0;
        end else begin
            case (state)
                hist_ctrl_pkg::IDLE: begin
                    if (run) state <= hist_ctrl_pkg::CLEAR;
                end
                hist_ctrl_pkg::CLEAR: begin
                    acq_cnt <= '0;
                    state   <= hist_ctrl_pkg::ACQUIRE;
                end
                hist_ctrl_pkg::ACQUIRE: begin
                    if (acq_end) begin
                        if (acq_cnt == hist_geom_pkg::ACQ_CNT_BITS'(hist_geom_pkg::ACQ_NUM - 1))
                            state <= hist_ctrl_pkg::SWAP;
                        else
                            acq_cnt <= acq_cnt + 1'b1;
                    end
                end
                hist_ctrl_pkg::SWAP: begin
                    wr_page     <= ~wr_page; // finished page goes to readout
                    frame_count <= frame_count + 1'b1;
                    state       <= run ? hist_ctrl_pkg::CLEAR : hist_ctrl_pkg::IDLE;
                end
                default: state <= hist_ctrl_pkg::IDLE;
            endcase
        end
    end

    // a window is only counted on an acq_end seen in ACQUIRE
    a_acq_counted: assert property (@(posedge clk) disable iff (!res)
        (acq_cnt != $past(acq_cnt) && acq_cnt != '0)
            |-> $past(state == hist_ctrl_pkg::ACQUIRE && acq_end));

    // every acquisition starts on a freshly cleared page
    a_clear_first: assert property (@(posedge clk) disable iff (!res)
        $rose(acq_active) |-> $past(clr_page) && !clr_page);

endmodule

// File: hw/hist_ctrl_pkg.sv
package hist_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        CLEAR   = 2'd1,
        ACQUIRE = 2'd2,
        SWAP    = 2'd3
    } seq_state_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    localparam int ADDR_BITS = 12;
    localparam int DATA_BITS = 32;
    localparam int FRAME_BITS = 8;

    // byte offsets
    localparam logic [ADDR_BITS-1:0] ADDR_CTRL     = 12'h000;
    localparam logic [ADDR_BITS-1:0] ADDR_STATUS   = 12'h004;
    localparam logic [ADDR_BITS-1:0] ADDR_BIN_BASE = 12'h100;

endpackage

// File: hw/hist_geom_pkg.sv
package hist_geom_pkg;

    // one bank per pixel
    localparam int NUM_BANKS = 4;
    localparam int PIX_BITS = 2;

    // timing code per event
    localparam int BIN_BITS = 4;
    localparam int NUM_BINS = 16;

    localparam int COUNT_BITS = 8; // saturates at all ones

    // acquisition windows per frame
    localparam int ACQ_NUM = 3;
    localparam int ACQ_CNT_BITS = $clog2(ACQ_NUM);

endpackage
